// File: rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ==================================================
// core widths
// ==================================================

// data and address width
`define RV_XLEN 32

// register file geometry
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

// first fetch address
`define RV_RESET_PC 32'h0000_0000

`endif

// File: rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

    // ==================================================
    // encodings
    // ==================================================

    // major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // R view of the instruction word
    typedef struct packed {
        logic [6:0]               funct7;
        logic [`RV_REG_IDX_W-1:0] rs2;
        logic [`RV_REG_IDX_W-1:0] rs1;
        logic [2:0]               funct3;
        logic [`RV_REG_IDX_W-1:0] rd;
        logic [6:0]               opcode;
    } insn_r_t;

    // I/S view, S immediate is {imm_hi, rd_imm_lo}
    typedef struct packed {
        logic [6:0]               imm_hi;
        logic [4:0]               imm_mid;
        logic [`RV_REG_IDX_W-1:0] rs1;
        logic [2:0]               funct3;
        logic [4:0]               rd_imm_lo;
        logic [6:0]               opcode;
    } insn_is_t;

    typedef union packed {
        insn_r_t  rtype;
        insn_is_t istype;
    } insn_u;

    // ==================================================
    // stage packets
    // ==================================================

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        insn_u               insn;
    } fetch_pkt_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]      pc;
        logic [`RV_XLEN-1:0]      op_a;
        logic [`RV_XLEN-1:0]      op_b;
        logic [`RV_XLEN-1:0]      store_data;
        logic [`RV_XLEN-1:0]      imm;
        logic [`RV_REG_IDX_W-1:0] rd;
        alu_op_e                  alu_op;
        logic                     is_load;
        logic                     is_store;
        logic                     is_branch;
        logic                     branch_ne;
        logic                     is_jal;
        logic                     writes_rd;
    } dec_pkt_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]      result;
        logic [`RV_XLEN-1:0]      store_data;
        logic [`RV_XLEN-1:0]      next_pc;
        logic [`RV_REG_IDX_W-1:0] rd;
        logic                     is_load;
        logic                     is_store;
        logic                     writes_rd;
    } ex_pkt_t;

    typedef struct packed {
        logic                we;
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

// File: reg_file.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module reg_file (
    input  logic                     sys_clk,
    input  logic                     sys_rst,
    input  logic [`RV_REG_IDX_W-1:0] rs1_addr,
    input  logic [`RV_REG_IDX_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]      rs1_data,
    output logic [`RV_XLEN-1:0]      rs2_data,
    input  logic                     we,
    input  logic [`RV_REG_IDX_W-1:0] waddr,
    input  logic [`RV_XLEN-1:0]      wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // async read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            // x0 never written
            regs[waddr] <= wdata;
        end
    end

    a_waddr_range: assert property (@(posedge sys_clk) disable iff (sys_rst)
        we |-> !$isunknown(waddr) && (waddr < `RV_REG_COUNT));

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module fetch_stage (
    input  logic                sys_clk,
    input  logic                sys_rst,
    output logic                imem_req_valid,
    input  logic                imem_req_ready,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic                imem_rsp_valid,
    input  logic [`RV_XLEN-1:0] imem_rsp_data,
    input  logic                retire_valid,
    input  logic [`RV_XLEN-1:0] retire_pc,
    output logic                out_valid,
    input  logic                out_ready,
    output rv_pkg::fetch_pkt_t  out_pkt
);

    logic [`RV_XLEN-1:0] pc;
    logic                started;
    // request accepted, response pending
    logic                waiting;

    assign imem_addr = pc;

    // ==================================================
    // request side
    // ==================================================

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            pc             <= `RV_RESET_PC;
            started        <= 1'b0;
            imem_req_valid <= 1'b0;
            waiting        <= 1'b0;
        end else begin
            if (!started) begin
                started        <= 1'b1;
                imem_req_valid <= 1'b1;
            end else if (retire_valid) begin
                // refetch from the retired instruction's next pc
                pc             <= retire_pc;
                imem_req_valid <= 1'b1;
            end else if (imem_req_ready) begin
                imem_req_valid <= 1'b0;
            end

            if (imem_req_valid && imem_req_ready) begin
                waiting <= 1'b1;
            end else if (imem_rsp_valid) begin
                waiting <= 1'b0;
            end
        end
    end

    // ==================================================
    // response capture
    // ==================================================

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            out_valid <= 1'b0;
        end else if (imem_rsp_valid) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (imem_rsp_valid) begin
            out_pkt.pc   <= pc;
            out_pkt.insn <= imem_rsp_data;
        end
    end

    a_rsp_outstanding: assert property (@(posedge sys_clk) disable iff (sys_rst)
        imem_rsp_valid |-> waiting);

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module decode_stage (
    input  logic                     sys_clk,
    input  logic                     sys_rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  rv_pkg::fetch_pkt_t       in_pkt,
    output logic [`RV_REG_IDX_W-1:0] rs1_addr,
    output logic [`RV_REG_IDX_W-1:0] rs2_addr,
    input  logic [`RV_XLEN-1:0]      rs1_data,
    input  logic [`RV_XLEN-1:0]      rs2_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output rv_pkg::dec_pkt_t         out_pkt
);

    rv_pkg::insn_u       insn;
    rv_pkg::dec_pkt_t    dec;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign insn     = in_pkt.insn;
    assign rs1_addr = insn.rtype.rs1;
    assign rs2_addr = insn.rtype.rs2;
    assign in_ready = !out_valid || out_ready;

    // ==================================================
    // immediates
    // ==================================================

    assign imm_i = {{20{insn.istype.imm_hi[6]}}, insn.istype.imm_hi, insn.istype.imm_mid};
    assign imm_s = {{20{insn.istype.imm_hi[6]}}, insn.istype.imm_hi, insn.istype.rd_imm_lo};
    assign imm_b = {{20{insn.istype.imm_hi[6]}}, insn.istype.rd_imm_lo[0],
                    insn.istype.imm_hi[5:0], insn.istype.rd_imm_lo[4:1], 1'b0};
    assign imm_u = {insn.rtype.funct7, insn.rtype.rs2, insn.rtype.rs1,
                    insn.rtype.funct3, 12'b0};
    assign imm_j = {{12{insn.istype.imm_hi[6]}}, insn.istype.rs1, insn.istype.funct3,
                    insn.istype.imm_mid[0], insn.istype.imm_hi[5:0],
                    insn.istype.imm_mid[4:1], 1'b0};

    // ==================================================
    // control decode
    // ==================================================

    always_comb begin
        dec            = '0;
        dec.pc         = in_pkt.pc;
        dec.op_a       = rs1_data;
        dec.op_b       = rs2_data;
        dec.store_data = rs2_data;
        dec.imm        = imm_i;
        dec.rd         = insn.rtype.rd;
        dec.alu_op     = rv_pkg::ALU_ADD;
        case (rv_pkg::opcode_e'(insn.rtype.opcode))
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP: begin
                if (insn.rtype.opcode == rv_pkg::OPC_OP_IMM) begin
                    dec.op_b = imm_i;
                end
                dec.writes_rd = 1'b1;
                case (insn.rtype.funct3)
                    3'b000: begin
                        // sub only for register form
                        if (insn.rtype.opcode == rv_pkg::OPC_OP && insn.rtype.funct7[5]) begin
                            dec.alu_op = rv_pkg::ALU_SUB;
                        end
                    end
                    3'b010: dec.alu_op = rv_pkg::ALU_SLT;
                    3'b100: dec.alu_op = rv_pkg::ALU_XOR;
                    3'b110: dec.alu_op = rv_pkg::ALU_OR;
                    3'b111: dec.alu_op = rv_pkg::ALU_AND;
                    // shifts and unsigned compares retire as no-ops
                    default: dec.writes_rd = 1'b0;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                dec.op_b      = imm_u;
                dec.alu_op    = rv_pkg::ALU_PASS_B;
                dec.writes_rd = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                dec.is_load   = 1'b1;
                dec.writes_rd = 1'b1;
                dec.op_b      = imm_i;
            end
            rv_pkg::OPC_STORE: begin
                dec.is_store = 1'b1;
                dec.op_b     = imm_s;
            end
            rv_pkg::OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = (insn.rtype.funct3[2:1] == 2'b00);
                dec.branch_ne = insn.rtype.funct3[0];
            end
            rv_pkg::OPC_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            default: dec.writes_rd = 1'b0;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // operands sampled at acceptance
    always_ff @(posedge sys_clk) begin
        if (in_valid && in_ready) begin
            out_pkt <= dec;
        end
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module execute_stage (
    input  logic             sys_clk,
    input  logic             sys_rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  rv_pkg::dec_pkt_t in_pkt,
    output logic             out_valid,
    input  logic             out_ready,
    output rv_pkg::ex_pkt_t  out_pkt
);

    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] target;
    logic                taken;
    rv_pkg::ex_pkt_t     ex;

    assign in_ready = !out_valid || out_ready;

    // ==================================================
    // ALU
    // ==================================================

    always_comb begin
        case (in_pkt.alu_op)
            rv_pkg::ALU_ADD:    alu_result = in_pkt.op_a + in_pkt.op_b;
            rv_pkg::ALU_SUB:    alu_result = in_pkt.op_a - in_pkt.op_b;
            rv_pkg::ALU_SLT: begin
                alu_result = {31'b0, $signed(in_pkt.op_a) < $signed(in_pkt.op_b)};
            end
            rv_pkg::ALU_XOR:    alu_result = in_pkt.op_a ^ in_pkt.op_b;
            rv_pkg::ALU_OR:     alu_result = in_pkt.op_a | in_pkt.op_b;
            rv_pkg::ALU_AND:    alu_result = in_pkt.op_a & in_pkt.op_b;
            rv_pkg::ALU_PASS_B: alu_result = in_pkt.op_b;
            default:            alu_result = in_pkt.op_a + in_pkt.op_b;
        endcase
    end

    // ==================================================
    // branch and next pc
    // ==================================================

    assign pc_plus4 = in_pkt.pc + 32'd4;
    assign target   = in_pkt.pc + in_pkt.imm;
    // beq taken on equal, bne on not equal
    assign taken    = in_pkt.is_branch && ((in_pkt.op_a == in_pkt.op_b) ^ in_pkt.branch_ne);

    always_comb begin
        ex.result     = in_pkt.is_jal ? pc_plus4 : alu_result;
        ex.store_data = in_pkt.store_data;
        ex.next_pc    = (taken || in_pkt.is_jal) ? target : pc_plus4;
        ex.rd         = in_pkt.rd;
        ex.is_load    = in_pkt.is_load;
        ex.is_store   = in_pkt.is_store;
        ex.writes_rd  = in_pkt.writes_rd;
    end

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (in_valid && in_ready) begin
            out_pkt <= ex;
        end
    end

endmodule

// File: mem_stage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module mem_stage (
    input  logic                     sys_clk,
    input  logic                     sys_rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  rv_pkg::ex_pkt_t          in_pkt,
    output logic                     dmem_req_valid,
    input  logic                     dmem_req_ready,
    output rv_pkg::dmem_req_t        dmem_req,
    input  logic                     dmem_rsp_valid,
    input  logic [`RV_XLEN-1:0]      dmem_rsp_data,
    output logic                     rf_we,
    output logic [`RV_REG_IDX_W-1:0] rf_waddr,
    output logic [`RV_XLEN-1:0]      rf_wdata,
    output logic                     retire_valid,
    output logic [`RV_XLEN-1:0]      retire_pc
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_e;

    state_e              state;
    rv_pkg::ex_pkt_t     pkt;
    logic [`RV_XLEN-1:0] load_data;

    assign in_ready       = (state == ST_IDLE);
    assign dmem_req_valid = (state == ST_REQ);
    assign dmem_req.we    = pkt.is_store;
    assign dmem_req.addr  = pkt.result;
    assign dmem_req.wdata = pkt.store_data;

    // writeback and retire follow the held packet
    assign rf_waddr  = pkt.rd;
    assign rf_wdata  = pkt.is_load ? load_data : pkt.result;
    assign retire_pc = pkt.next_pc;

    // ==================================================
    // access FSM
    // ==================================================

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state        <= ST_IDLE;
            rf_we        <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            rf_we        <= 1'b0;
            retire_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (in_valid) begin
                        if (in_pkt.is_load || in_pkt.is_store) begin
                            state <= ST_REQ;
                        end else begin
                            rf_we        <= in_pkt.writes_rd;
                            retire_valid <= 1'b1;
                        end
                    end
                end
                ST_REQ: begin
                    if (dmem_req_ready) begin
                        if (pkt.is_store) begin
                            retire_valid <= 1'b1;
                            state        <= ST_IDLE;
                        end else begin
                            state <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT: begin
                    if (dmem_rsp_valid) begin
                        rf_we        <= pkt.writes_rd;
                        retire_valid <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (in_valid && in_ready) begin
            pkt <= in_pkt;
        end
        if ((state == ST_WAIT) && dmem_rsp_valid) begin
            load_data <= dmem_rsp_data;
        end
    end

    a_req_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
        dmem_req_valid && !dmem_req_ready |=> dmem_req_valid && $stable(dmem_req));

endmodule

// File: rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core (
    input  logic                sys_clk,
    input  logic                sys_rst,
    output logic                imem_req_valid,
    input  logic                imem_req_ready,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic                imem_rsp_valid,
    input  logic [`RV_XLEN-1:0] imem_rsp_data,
    output logic                dmem_req_valid,
    input  logic                dmem_req_ready,
    output rv_pkg::dmem_req_t   dmem_req,
    input  logic                dmem_rsp_valid,
    input  logic [`RV_XLEN-1:0] dmem_rsp_data
);

    // stage links
    logic               f_valid;
    logic               f_ready;
    rv_pkg::fetch_pkt_t f_pkt;
    logic               d_valid;
    logic               d_ready;
    rv_pkg::dec_pkt_t   d_pkt;
    logic               e_valid;
    logic               e_ready;
    rv_pkg::ex_pkt_t    e_pkt;

    // register file ports
    logic [`RV_REG_IDX_W-1:0] rs1_addr;
    logic [`RV_REG_IDX_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]      rs1_data;
    logic [`RV_XLEN-1:0]      rs2_data;
    logic                     rf_we;
    logic [`RV_REG_IDX_W-1:0] rf_waddr;
    logic [`RV_XLEN-1:0]      rf_wdata;

    logic                retire_valid;
    logic [`RV_XLEN-1:0] retire_pc;

    // ==================================================
    // stages
    // ==================================================

    fetch_stage u_fetch (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .imem_req_valid(imem_req_valid), .imem_req_ready(imem_req_ready),
        .imem_addr(imem_addr),
        .imem_rsp_valid(imem_rsp_valid), .imem_rsp_data(imem_rsp_data),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .out_valid(f_valid), .out_ready(f_ready), .out_pkt(f_pkt)
    );

    decode_stage u_decode (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .in_valid(f_valid), .in_ready(f_ready), .in_pkt(f_pkt),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .out_valid(d_valid), .out_ready(d_ready), .out_pkt(d_pkt)
    );

    execute_stage u_execute (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .in_valid(d_valid), .in_ready(d_ready), .in_pkt(d_pkt),
        .out_valid(e_valid), .out_ready(e_ready), .out_pkt(e_pkt)
    );

    mem_stage u_mem (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .in_valid(e_valid), .in_ready(e_ready), .in_pkt(e_pkt),
        .dmem_req_valid(dmem_req_valid), .dmem_req_ready(dmem_req_ready),
        .dmem_req(dmem_req),
        .dmem_rsp_valid(dmem_rsp_valid), .dmem_rsp_data(dmem_rsp_data),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc)
    );

    reg_file u_reg_file (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_rv_core;

    localparam int NUM_ROWS = 11;
    localparam int ROW_LEN  = 8;
    // two passes of up to 8 instructions per row at about 20 cycles each plus reset slack
    localparam longint TIMEOUT_NS = 2 * NUM_ROWS * (ROW_LEN * 20 + 10) * 20;

    logic                sys_clk;
    logic                sys_rst;
    logic                imem_req_valid;
    logic                imem_req_ready;
    logic [`RV_XLEN-1:0] imem_addr;
    logic                imem_rsp_valid;
    logic [`RV_XLEN-1:0] imem_rsp_data;
    logic                dmem_req_valid;
    logic                dmem_req_ready;
    rv_pkg::dmem_req_t   dmem_req;
    logic                dmem_rsp_valid;
    logic [`RV_XLEN-1:0] dmem_rsp_data;

    logic [31:0] prog [NUM_ROWS][ROW_LEN];
    logic [31:0] expected [NUM_ROWS];
    logic [31:0] imem [16];
    logic [31:0] dmem [256];
    logic [31:0] rng_state;
    logic        random_delay;
    logic        store_seen;
    logic [31:0] store_val;

    rv_core rv_core_inst (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .imem_req_valid(imem_req_valid), .imem_req_ready(imem_req_ready),
        .imem_addr(imem_addr),
        .imem_rsp_valid(imem_rsp_valid), .imem_rsp_data(imem_rsp_data),
        .dmem_req_valid(dmem_req_valid), .dmem_req_ready(dmem_req_ready),
        .dmem_req(dmem_req),
        .dmem_rsp_valid(dmem_rsp_valid), .dmem_rsp_data(dmem_rsp_data)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    // ==================================================
    // helpers
    // ==================================================

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [2:0] draw_delay();
        if (!random_delay) begin
            return 3'd0;
        end
        rng_state = xorshift(rng_state);
        return {1'b0, rng_state[1:0]};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // store word rs2 to imm(rs1)
    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] exp_val);
        if (actual !== exp_val) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, actual, exp_val);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ==================================================
    // memory models
    // ==================================================

    logic [2:0]  i_req_cnt;
    logic [2:0]  i_rsp_cnt;
    logic        i_pend;
    logic [31:0] i_addr;

    always @(posedge sys_clk) begin
        if (sys_rst) begin
            imem_req_ready <= 1'b0;
            imem_rsp_valid <= 1'b0;
            i_pend         <= 1'b0;
            i_req_cnt      <= draw_delay();
        end else begin
            imem_rsp_valid <= 1'b0;
            if (imem_req_valid && imem_req_ready) begin
                imem_req_ready <= 1'b0;
                i_pend         <= 1'b1;
                i_addr         <= imem_addr;
                i_rsp_cnt      <= draw_delay();
                i_req_cnt      <= draw_delay();
            end else if (imem_req_valid) begin
                if (i_req_cnt == 0) begin
                    imem_req_ready <= 1'b1;
                end else begin
                    i_req_cnt <= i_req_cnt - 1;
                end
            end
            if (i_pend) begin
                if (i_rsp_cnt == 0) begin
                    imem_rsp_valid <= 1'b1;
                    imem_rsp_data  <= imem[i_addr[5:2]];
                    i_pend         <= 1'b0;
                end else begin
                    i_rsp_cnt <= i_rsp_cnt - 1;
                end
            end
        end
    end

    logic [2:0]  d_req_cnt;
    logic [2:0]  d_rsp_cnt;
    logic        d_pend;
    logic [31:0] d_addr;

    always @(posedge sys_clk) begin
        if (sys_rst) begin
            dmem_req_ready <= 1'b0;
            dmem_rsp_valid <= 1'b0;
            d_pend         <= 1'b0;
            store_seen     <= 1'b0;
            d_req_cnt      <= draw_delay();
        end else begin
            dmem_rsp_valid <= 1'b0;
            if (dmem_req_valid && dmem_req_ready) begin
                dmem_req_ready <= 1'b0;
                d_req_cnt      <= draw_delay();
                if (dmem_req.we) begin
                    dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
                    if (dmem_req.addr == 32'h100) begin
                        store_seen <= 1'b1;
                        store_val  <= dmem_req.wdata;
                    end
                end else begin
                    d_pend    <= 1'b1;
                    d_addr    <= dmem_req.addr;
                    d_rsp_cnt <= draw_delay();
                end
            end else if (dmem_req_valid) begin
                if (d_req_cnt == 0) begin
                    dmem_req_ready <= 1'b1;
                end else begin
                    d_req_cnt <= d_req_cnt - 1;
                end
            end
            if (d_pend) begin
                if (d_rsp_cnt == 0) begin
                    dmem_rsp_valid <= 1'b1;
                    dmem_rsp_data  <= dmem[d_addr[9:2]];
                    d_pend         <= 1'b0;
                end else begin
                    d_rsp_cnt <= d_rsp_cnt - 1;
                end
            end
        end
    end

    // ==================================================
    // program table
    // ==================================================

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int k = 0; k < ROW_LEN; k++) begin
                prog[r][k] = 32'h0000_0013;
            end
        end
        // immediate chain with negative immediates
        prog[0][0] = enc_i(12'd100, 5'd0, 3'b000, 5'd1, 7'b0010011);
        prog[0][1] = enc_i(12'hfff, 5'd1, 3'b100, 5'd2, 7'b0010011);
        prog[0][2] = enc_i(12'h0f0, 5'd2, 3'b110, 5'd3, 7'b0010011);
        prog[0][3] = enc_i(12'hff7, 5'd3, 3'b111, 5'd4, 7'b0010011);
        prog[0][4] = enc_sw(12'h100, 5'd4, 5'd0);
        expected[0] = 32'hffff_fff3;
        // slti with -101 < -100 but not < -102
        prog[1][0] = enc_i(-12'sd101, 5'd0, 3'b000, 5'd1, 7'b0010011);
        prog[1][1] = enc_i(-12'sd100, 5'd1, 3'b010, 5'd2, 7'b0010011);
        prog[1][2] = enc_i(-12'sd102, 5'd1, 3'b010, 5'd3, 7'b0010011);
        prog[1][3] = enc_i(12'd2, 5'd3, 3'b000, 5'd3, 7'b0010011);
        prog[1][4] = enc_r(7'd0, 5'd3, 5'd2, 3'b000, 5'd4);
        prog[1][5] = enc_sw(12'h100, 5'd4, 5'd0);
        expected[1] = 32'd3;
        // add sub slt xor on lui operands
        prog[2][0] = enc_lui(20'h12345, 5'd1);
        prog[2][1] = enc_lui(20'hfffff, 5'd2);
        prog[2][2] = enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd3);
        prog[2][3] = enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);
        prog[2][4] = enc_r(7'd0, 5'd1, 5'd4, 3'b010, 5'd5);
        prog[2][5] = enc_r(7'd0, 5'd5, 5'd3, 3'b100, 5'd6);
        prog[2][6] = enc_sw(12'h100, 5'd6, 5'd0);
        expected[2] = 32'h1234_4001;
        // or and with signed slt
        prog[3][0] = enc_lui(20'hf0f0f, 5'd1);
        prog[3][1] = enc_i(12'h0f0, 5'd1, 3'b000, 5'd1, 7'b0010011);
        prog[3][2] = enc_lui(20'h0ff00, 5'd2);
        prog[3][3] = enc_r(7'd0, 5'd2, 5'd1, 3'b110, 5'd3);
        prog[3][4] = enc_r(7'd0, 5'd2, 5'd3, 3'b111, 5'd4);
        prog[3][5] = enc_r(7'd0, 5'd4, 5'd1, 3'b010, 5'd5);
        prog[3][6] = enc_r(7'd0, 5'd5, 5'd4, 3'b000, 5'd6);
        prog[3][7] = enc_sw(12'h100, 5'd6, 5'd0);
        expected[3] = 32'h0ff0_0001;
        // load from 0x7c + 4
        prog[4][0] = enc_i(12'h07c, 5'd0, 3'b000, 5'd1, 7'b0010011);
        prog[4][1] = enc_i(12'd4, 5'd1, 3'b010, 5'd2, 7'b0000011);
        prog[4][2] = enc_i(12'd5, 5'd2, 3'b000, 5'd3, 7'b0010011);
        prog[4][3] = enc_sw(12'h100, 5'd3, 5'd0);
        expected[4] = 32'h1234_567d;
        // beq and bne where taken skips the increment
        for (int b = 0; b < 4; b++) begin
            prog[5+b][0] = enc_i(12'd7, 5'd0, 3'b000, 5'd1, 7'b0010011);
            prog[5+b][1] = enc_i((b == 0 || b == 3) ? 12'd7 : 12'd8, 5'd0, 3'b000, 5'd2,
                                 7'b0010011);
            prog[5+b][2] = enc_b(13'd8, 5'd2, 5'd1, (b < 2) ? 3'b000 : 3'b001);
            prog[5+b][3] = enc_i(12'd1, 5'd1, 3'b000, 5'd1, 7'b0010011);
            prog[5+b][4] = enc_sw(12'h100, 5'd1, 5'd0);
            expected[5+b] = (b == 0 || b == 2) ? 32'd7 : 32'd8;
        end
        // jal at pc 4 links 8
        prog[9][0] = enc_i(12'h055, 5'd0, 3'b000, 5'd2, 7'b0010011);
        prog[9][1] = enc_jal(21'd8, 5'd1);
        prog[9][2] = enc_i(12'd1, 5'd0, 3'b000, 5'd2, 7'b0010011);
        prog[9][3] = enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd3);
        prog[9][4] = enc_sw(12'h100, 5'd3, 5'd0);
        expected[9] = 32'h0000_005d;
        // write to x0 is dropped
        prog[10][0] = enc_i(12'd9, 5'd0, 3'b000, 5'd0, 7'b0010011);
        prog[10][1] = enc_sw(12'h100, 5'd0, 5'd0);
        expected[10] = 32'd0;
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        #(TIMEOUT_NS);
        $display("core hung: result store never seen before the watchdog expired");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        sys_rst        = 1'b1;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_data  = '0;
        dmem_req_ready = 1'b0;
        dmem_rsp_valid = 1'b0;
        dmem_rsp_data  = '0;
        rng_state      = 32'h77cc;
        random_delay   = 1'b0;
        build_table();
        for (int pass = 0; pass < 2; pass++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                @(posedge sys_clk);
                sys_rst      <= 1'b1;
                random_delay <= (pass == 1);
                for (int k = 0; k < 16; k++) begin
                    imem[k] = (k < ROW_LEN) ? prog[r][k] : 32'h0000_0013;
                end
                for (int a = 0; a < 256; a++) begin
                    dmem[a] = 32'hd000_0000 | (a << 2);
                end
                dmem[32'h80 >> 2] = 32'h1234_5678;
                repeat (3) @(posedge sys_clk);
                sys_rst <= 1'b0;
                @(negedge sys_clk);
                while (!store_seen) begin
                    @(negedge sys_clk);
                end
                check($sformatf("dmem[0x100] row %0d pass %0d", r, pass), store_val,
                      expected[r]);
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
rv_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
rv_core.sv
tb_rv_core.sv
